// ==== project.f ====
source/wq_pkg.sv
source/wq_sq_context.sv
source/wq_wqe_fetch.sv
source/wq_req_segmenter.sv
source/wq_manager_top.sv
test/tb_wqe_mem.sv
test/tb_wq_manager.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the work queue manager testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tb_wq_manager -o tb_wq_manager_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_wq_manager_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "=== PASS ==="; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== source/wq_manager_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module wq_manager_top (
  input  wire logic         axil_aclk_i,
  input  wire logic         rstn_i,
  input  wire logic         sq_cfg_wr_i,
  input  wq_pkg::sq_idx_t   sq_cfg_idx_i,
  input  wq_pkg::sq_cfg_t   sq_cfg_i,
  input  wire logic         sq_db_i,
  input  wq_pkg::sq_idx_t   sq_db_idx_i,
  input  wq_pkg::ring_idx_t sq_pi_i,
  output logic              m_axi_arvalid_o,
  input  wire logic         m_axi_arready_i,
  output wq_pkg::addr_t     m_axi_araddr_o,
  output logic [7:0]        m_axi_arlen_o,
  output logic [2:0]        m_axi_arsize_o,
  output logic [1:0]        m_axi_arburst_o,
  output logic [3:0]        m_axi_arcache_o,
  output logic [2:0]        m_axi_arprot_o,
  output logic              m_axi_arid_o,
  output logic              m_axi_arlock_o,
  input  wire logic         m_axi_rvalid_i,
  output logic              m_axi_rready_o,
  input  wq_pkg::wqe_t      m_axi_rdata_i,
  input  wire logic         m_axi_rlast_i,
  input  wire logic         m_axi_rid_i,
  input  wire logic [1:0]   m_axi_rresp_i,
  output logic              m_rdma_req_valid_o,
  input  wire logic         m_rdma_req_ready_i,
  output wq_pkg::rdma_req_t m_rdma_req_o
);
  import wq_pkg::*;

  logic       fetch_req_valid;
  fetch_req_t fetch_req;
  mtu_code_t  mtu_code;
  addr_t      local_vaddr;
  logic       wqe_valid;
  wqe_t       wqe;
  sq_idx_t    wqe_idx;
  logic       wqe_done;
  sq_idx_t    done_idx;

  wq_sq_context wq_sq_context_inst (
    .axil_aclk_i       (axil_aclk_i),
    .rstn_i            (rstn_i),
    .cfg_wr_i          (sq_cfg_wr_i),
    .cfg_idx_i         (sq_cfg_idx_i),
    .cfg_i             (sq_cfg_i),
    .db_i              (sq_db_i),
    .db_idx_i          (sq_db_idx_i),
    .db_pi_i           (sq_pi_i),
    .wqe_done_i        (wqe_done),
    .done_idx_i        (done_idx),
    .fetch_req_valid_o (fetch_req_valid),
    .fetch_req_o       (fetch_req),
    .mtu_code_o        (mtu_code),
    .local_vaddr_o     (local_vaddr)
  );

  wq_wqe_fetch wq_wqe_fetch_inst (
    .axil_aclk_i     (axil_aclk_i),
    .rstn_i          (rstn_i),
    .req_valid_i     (fetch_req_valid),
    .req_i           (fetch_req),
    .m_axi_arvalid_o (m_axi_arvalid_o),
    .m_axi_arready_i (m_axi_arready_i),
    .m_axi_araddr_o  (m_axi_araddr_o),
    .m_axi_arlen_o   (m_axi_arlen_o),
    .m_axi_arsize_o  (m_axi_arsize_o),
    .m_axi_arburst_o (m_axi_arburst_o),
    .m_axi_arcache_o (m_axi_arcache_o),
    .m_axi_arprot_o  (m_axi_arprot_o),
    .m_axi_arid_o    (m_axi_arid_o),
    .m_axi_arlock_o  (m_axi_arlock_o),
    .m_axi_rvalid_i  (m_axi_rvalid_i),
    .m_axi_rready_o  (m_axi_rready_o),
    .m_axi_rdata_i   (m_axi_rdata_i),
    .m_axi_rlast_i   (m_axi_rlast_i),
    .m_axi_rid_i     (m_axi_rid_i),
    .m_axi_rresp_i   (m_axi_rresp_i),
    .wqe_valid_o     (wqe_valid),
    .wqe_o           (wqe),
    .sq_idx_o        (wqe_idx)
  );

  wq_req_segmenter wq_req_segmenter_inst (
    .axil_aclk_i        (axil_aclk_i),
    .rstn_i             (rstn_i),
    .wqe_valid_i        (wqe_valid),
    .wqe_i              (wqe),
    .sq_idx_i           (wqe_idx),
    .mtu_code_i         (mtu_code),
    .local_vaddr_i      (local_vaddr),
    .m_rdma_req_valid_o (m_rdma_req_valid_o),
    .m_rdma_req_ready_i (m_rdma_req_ready_i),
    .m_rdma_req_o       (m_rdma_req_o),
    .wqe_done_o         (wqe_done),
    .done_idx_o         (done_idx)
  );

endmodule

`default_nettype wire

// ==== source/wq_pkg.sv ====
`default_nettype none

package wq_pkg;

  ////////////////////////////////////////
  // Widths and limits
  ////////////////////////////////////////
  localparam int NUM_SQ         = 8;
  localparam int WQE_BITS       = 512;
  localparam int WQE_BYTES_LOG2 = 6;

  typedef logic [2:0]          sq_idx_t;
  typedef logic [9:0]          qpn_t;
  typedef logic [31:0]         ring_idx_t;
  typedef logic [63:0]         addr_t;
  typedef logic [31:0]         len_t;
  typedef logic [2:0]          mtu_code_t;
  typedef logic [4:0]          rdma_opc_t;
  typedef logic [WQE_BITS-1:0] wqe_t;

  // MTU in bytes is MTU_BASE << code
  localparam mtu_code_t MTU_CODE_MAX = 3'd4;
  localparam int        MTU_BASE     = 256;

  // Field positions inside a 64-byte WQE
  localparam int WQE_LEN_LSB   = 96;
  localparam int WQE_OPC_LSB   = 128;
  localparam int WQE_RADDR_LSB = 160;

  localparam logic [7:0] WQE_OPC_WRITE = 8'h00;
  localparam logic [7:0] WQE_OPC_READ  = 8'h04;

  localparam rdma_opc_t OPC_WRITE_FIRST  = 5'h06;
  localparam rdma_opc_t OPC_WRITE_MIDDLE = 5'h07;
  localparam rdma_opc_t OPC_WRITE_LAST   = 5'h08;
  localparam rdma_opc_t OPC_WRITE_ONLY   = 5'h0a;
  localparam rdma_opc_t OPC_READ_REQ     = 5'h0c;

  ////////////////////////////////////////
  // AXI read channel constants
  ////////////////////////////////////////
  localparam logic       AR_ID         = 1'b1;
  localparam logic [7:0] AR_LEN        = 8'd0;
  localparam logic [1:0] AR_BURST_INCR = 2'b01;
  localparam logic [3:0] AR_CACHE      = 4'h2;
  localparam logic [2:0] AR_PROT       = 3'b010;
  localparam logic       AR_LOCK       = 1'b0;

  typedef enum logic [1:0] {FETCH_IDLE, FETCH_ADDR, FETCH_DATA, FETCH_DONE} fetch_state_t;
  typedef enum logic [1:0] {SEG_IDLE, SEG_ISSUE, SEG_WAIT} seg_state_t;

  typedef struct packed {
    logic      enable;
    mtu_code_t mtu_code;
    addr_t     ring_base;
    addr_t     local_vaddr;
  } sq_cfg_t;

  typedef struct packed {
    sq_idx_t sq_idx;
    addr_t   wqe_addr;
  } fetch_req_t;

  typedef struct packed {
    rdma_opc_t opcode;
    qpn_t      qpn;
    logic      last;
    len_t      len;
    addr_t     local_vaddr;
    addr_t     remote_vaddr;
  } rdma_req_t;

endpackage

`default_nettype wire

// ==== source/wq_req_segmenter.sv ====
`timescale 1ns/100ps
`default_nettype none

module wq_req_segmenter (
  input  wire logic         axil_aclk_i,
  input  wire logic         rstn_i,
  input  wire logic         wqe_valid_i,
  input  wq_pkg::wqe_t      wqe_i,
  input  wq_pkg::sq_idx_t   sq_idx_i,
  input  wq_pkg::mtu_code_t mtu_code_i,
  input  wq_pkg::addr_t     local_vaddr_i,
  output logic              m_rdma_req_valid_o,
  input  wire logic         m_rdma_req_ready_i,
  output wq_pkg::rdma_req_t m_rdma_req_o,
  output logic              wqe_done_o,
  output wq_pkg::sq_idx_t   done_idx_o
);
  import wq_pkg::*;

  seg_state_t state_q;
  rdma_req_t  req_q;
  len_t       rem_q;
  len_t       mtu_q;
  sq_idx_t    idx_q;

  logic [7:0] wqe_opc;
  len_t       wqe_len;
  len_t       wqe_mtu;
  logic       wqe_supported;
  rdma_req_t  first_req;
  len_t       first_rem;
  rdma_req_t  next_req;
  len_t       next_rem;

  ////////////////////////////////////////
  // First request from a fresh WQE
  ////////////////////////////////////////
  always_comb begin
    wqe_opc       = wqe_i[WQE_OPC_LSB +: 8];
    wqe_len       = wqe_i[WQE_LEN_LSB +: 32];
    wqe_mtu       = len_t'(MTU_BASE) << mtu_code_i;
    wqe_supported = (wqe_opc == WQE_OPC_WRITE) || (wqe_opc == WQE_OPC_READ);

    first_req.qpn          = qpn_t'(sq_idx_i);
    first_req.local_vaddr  = local_vaddr_i;
    first_req.remote_vaddr = wqe_i[WQE_RADDR_LSB +: 64];
    first_req.len          = wqe_len;
    first_req.last         = 1'b1;
    first_rem              = '0;
    if (wqe_opc == WQE_OPC_READ) begin
      first_req.opcode = OPC_READ_REQ;
    end else if (wqe_len <= wqe_mtu) begin
      first_req.opcode = OPC_WRITE_ONLY;
    end else begin
      // Long write starts with a full MTU segment
      first_req.opcode = OPC_WRITE_FIRST;
      first_req.len    = wqe_mtu;
      first_req.last   = 1'b0;
      first_rem        = wqe_len - wqe_mtu;
    end
  end

  ////////////////////////////////////////
  // Follow-on MIDDLE or LAST segment
  ////////////////////////////////////////
  always_comb begin
    next_req              = req_q;
    next_req.local_vaddr  = req_q.local_vaddr + addr_t'(mtu_q);
    next_req.remote_vaddr = req_q.remote_vaddr + addr_t'(mtu_q);
    if (rem_q <= mtu_q) begin
      next_req.opcode = OPC_WRITE_LAST;
      next_req.len    = rem_q;
      next_req.last   = 1'b1;
      next_rem        = '0;
    end else begin
      next_req.opcode = OPC_WRITE_MIDDLE;
      next_req.len    = mtu_q;
      next_req.last   = 1'b0;
      next_rem        = rem_q - mtu_q;
    end
  end

  always_ff @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= SEG_IDLE;
    end else begin
      case (state_q)
        SEG_IDLE: begin
          // Unsupported opcodes are retired without a request
          if (wqe_valid_i) begin
            state_q <= wqe_supported ? SEG_ISSUE : SEG_WAIT;
          end
        end
        SEG_ISSUE: begin
          if (m_rdma_req_ready_i && req_q.last) begin
            state_q <= SEG_WAIT;
          end
        end
        default: state_q <= SEG_IDLE;
      endcase
    end
  end

  always_ff @(posedge axil_aclk_i) begin
    if (state_q == SEG_IDLE && wqe_valid_i) begin
      req_q <= first_req;
      rem_q <= first_rem;
      mtu_q <= wqe_mtu;
      idx_q <= sq_idx_i;
    end else if (state_q == SEG_ISSUE && m_rdma_req_ready_i && !req_q.last) begin
      req_q <= next_req;
      rem_q <= next_rem;
    end
  end

  assign m_rdma_req_valid_o = (state_q == SEG_ISSUE);
  assign m_rdma_req_o       = req_q;
  // Done pulse retires the WQE in the context
  assign wqe_done_o         = (state_q == SEG_WAIT);
  assign done_idx_o         = idx_q;

  a_req_stable: assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    m_rdma_req_valid_o && !m_rdma_req_ready_i |=>
      m_rdma_req_valid_o && $stable(m_rdma_req_o));

endmodule

`default_nettype wire

// ==== source/wq_sq_context.sv ====
`timescale 1ns/100ps
`default_nettype none

module wq_sq_context (
  input  wire logic               axil_aclk_i,
  input  wire logic               rstn_i,
  input  wire logic               cfg_wr_i,
  input  wq_pkg::sq_idx_t         cfg_idx_i,
  input  wq_pkg::sq_cfg_t         cfg_i,
  input  wire logic               db_i,
  input  wq_pkg::sq_idx_t         db_idx_i,
  input  wq_pkg::ring_idx_t       db_pi_i,
  input  wire logic               wqe_done_i,
  input  wq_pkg::sq_idx_t         done_idx_i,
  output logic                    fetch_req_valid_o,
  output wq_pkg::fetch_req_t      fetch_req_o,
  output wq_pkg::mtu_code_t       mtu_code_o,
  output wq_pkg::addr_t           local_vaddr_o
);
  import wq_pkg::*;

  sq_cfg_t   cfg_q [NUM_SQ];
  ring_idx_t pi_q  [NUM_SQ];
  ring_idx_t ci_q  [NUM_SQ];

  logic              busy_q;
  sq_idx_t           last_q;
  logic [NUM_SQ-1:0] pend;
  logic              pick_found;
  sq_idx_t           pick_idx;

  // Pending means enabled, legal MTU and unread entries
  always_comb begin
    for (int i = 0; i < NUM_SQ; i++) begin
      pend[i] = cfg_q[i].enable && (cfg_q[i].mtu_code <= MTU_CODE_MAX) &&
                (ci_q[i] < pi_q[i]);
    end
  end

  ////////////////////////////////////////
  // Round-robin pick after last served
  ////////////////////////////////////////
  always_comb begin
    sq_idx_t cand;
    pick_found = 1'b0;
    pick_idx   = last_q;
    for (int k = 1; k <= NUM_SQ; k++) begin
      cand = last_q + sq_idx_t'(k);
      if (!pick_found && pend[cand]) begin
        pick_found = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  // One WQE in flight at a time
  assign fetch_req_valid_o    = !busy_q && pick_found;
  assign fetch_req_o.sq_idx   = pick_idx;
  assign fetch_req_o.wqe_addr = cfg_q[pick_idx].ring_base +
                                (addr_t'(ci_q[pick_idx]) << WQE_BYTES_LOG2);

  // Config of the SQ whose WQE is in flight
  assign mtu_code_o    = cfg_q[last_q].mtu_code;
  assign local_vaddr_o = cfg_q[last_q].local_vaddr;

  always_ff @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      busy_q <= 1'b0;
      last_q <= '0;
      for (int i = 0; i < NUM_SQ; i++) begin
        cfg_q[i] <= '0;
        pi_q[i]  <= '0;
        ci_q[i]  <= '0;
      end
    end else begin
      if (cfg_wr_i) begin
        cfg_q[cfg_idx_i] <= cfg_i;
      end
      // Stale doorbells are dropped
      if (db_i && (db_pi_i > pi_q[db_idx_i])) begin
        pi_q[db_idx_i] <= db_pi_i;
      end
      if (fetch_req_valid_o) begin
        busy_q <= 1'b1;
        last_q <= pick_idx;
      end else if (wqe_done_i) begin
        busy_q           <= 1'b0;
        ci_q[done_idx_i] <= ci_q[done_idx_i] + 1'b1;
      end
    end
  end

  a_pi_monotonic: assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    db_i |=> pi_q[$past(db_idx_i)] >= $past(pi_q[db_idx_i]));

  // Completion must match the SQ that was fetched
  a_done_when_busy: assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    wqe_done_i |-> busy_q && (done_idx_i == last_q));

endmodule

`default_nettype wire

// ==== source/wq_wqe_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module wq_wqe_fetch (
  input  wire logic          axil_aclk_i,
  input  wire logic          rstn_i,
  input  wire logic          req_valid_i,
  input  wq_pkg::fetch_req_t req_i,
  output logic               m_axi_arvalid_o,
  input  wire logic          m_axi_arready_i,
  output wq_pkg::addr_t      m_axi_araddr_o,
  output logic [7:0]         m_axi_arlen_o,
  output logic [2:0]         m_axi_arsize_o,
  output logic [1:0]         m_axi_arburst_o,
  output logic [3:0]         m_axi_arcache_o,
  output logic [2:0]         m_axi_arprot_o,
  output logic               m_axi_arid_o,
  output logic               m_axi_arlock_o,
  input  wire logic          m_axi_rvalid_i,
  output logic               m_axi_rready_o,
  input  wq_pkg::wqe_t       m_axi_rdata_i,
  input  wire logic          m_axi_rlast_i,
  input  wire logic          m_axi_rid_i,
  input  wire logic [1:0]    m_axi_rresp_i,
  output logic               wqe_valid_o,
  output wq_pkg::wqe_t       wqe_o,
  output wq_pkg::sq_idx_t    sq_idx_o
);
  import wq_pkg::*;

  fetch_state_t state_q;
  addr_t        addr_q;
  sq_idx_t      idx_q;
  wqe_t         wqe_q;

  always_ff @(posedge axil_aclk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q <= FETCH_IDLE;
    end else begin
      case (state_q)
        FETCH_IDLE: if (req_valid_i) state_q <= FETCH_ADDR;
        FETCH_ADDR: if (m_axi_arready_i) state_q <= FETCH_DATA;
        FETCH_DATA: if (m_axi_rvalid_i && m_axi_rlast_i) state_q <= FETCH_DONE;
        default:    state_q <= FETCH_IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge axil_aclk_i) begin
    if (state_q == FETCH_IDLE && req_valid_i) begin
      addr_q <= req_i.wqe_addr;
      idx_q  <= req_i.sq_idx;
    end
    if (state_q == FETCH_DATA && m_axi_rvalid_i) begin
      wqe_q <= m_axi_rdata_i;
    end
  end

  assign m_axi_arvalid_o = (state_q == FETCH_ADDR);
  assign m_axi_araddr_o  = addr_q;
  assign m_axi_rready_o  = (state_q == FETCH_DATA);
  assign wqe_valid_o     = (state_q == FETCH_DONE);
  assign wqe_o           = wqe_q;
  assign sq_idx_o        = idx_q;

  // Single 64-byte beat per WQE
  assign m_axi_arlen_o   = AR_LEN;
  assign m_axi_arsize_o  = 3'(WQE_BYTES_LOG2);
  assign m_axi_arburst_o = AR_BURST_INCR;
  assign m_axi_arcache_o = AR_CACHE;
  assign m_axi_arprot_o  = AR_PROT;
  assign m_axi_arid_o    = AR_ID;
  assign m_axi_arlock_o  = AR_LOCK;

  a_araddr_stable: assert property (@(posedge axil_aclk_i) disable iff (!rstn_i)
    m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o));

endmodule

`default_nettype wire

// ==== test/tb_wq_manager.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_wq_manager;
  import wq_pkg::*;

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 8;
  localparam addr_t RING_ORIGIN  = 64'h0000_0040_0000_0000;
  localparam addr_t LOCAL_ORIGIN = 64'h0000_8000_0000_0000;

  logic       clk;
  logic       rstn;
  logic       cfg_wr;
  sq_idx_t    cfg_idx;
  sq_cfg_t    cfg;
  logic       db;
  sq_idx_t    db_idx;
  ring_idx_t  db_pi;
  logic       arvalid;
  logic       arready;
  addr_t      araddr;
  logic [7:0] arlen;
  logic [2:0] arsize;
  logic [1:0] arburst;
  logic [3:0] arcache;
  logic [2:0] arprot;
  logic       arid;
  logic       arlock;
  logic       rvalid;
  logic       rready;
  wqe_t       rdata;
  logic       rlast;
  logic       req_valid;
  logic       req_ready;
  rdma_req_t  req;

  sq_cfg_t   cfg_model [NUM_SQ];
  ring_idx_t pi_model  [NUM_SQ];
  ring_idx_t ci_model  [NUM_SQ];
  rdma_req_t exp_q [$];
  rdma_req_t exp_head;
  logic      exp_avail;
  int        served;
  int        cycles;
  int        cycle_limit;

  sq_idx_t   ar_sq;
  addr_t     exp_araddr;
  logic      ar_allowed;

  wq_manager_top wq_manager_top_inst (
    .axil_aclk_i(clk), .rstn_i(rstn),
    .sq_cfg_wr_i(cfg_wr), .sq_cfg_idx_i(cfg_idx), .sq_cfg_i(cfg),
    .sq_db_i(db), .sq_db_idx_i(db_idx), .sq_pi_i(db_pi),
    .m_axi_arvalid_o(arvalid), .m_axi_arready_i(arready), .m_axi_araddr_o(araddr),
    .m_axi_arlen_o(arlen), .m_axi_arsize_o(arsize), .m_axi_arburst_o(arburst),
    .m_axi_arcache_o(arcache), .m_axi_arprot_o(arprot), .m_axi_arid_o(arid),
    .m_axi_arlock_o(arlock), .m_axi_rvalid_i(rvalid), .m_axi_rready_o(rready),
    .m_axi_rdata_i(rdata), .m_axi_rlast_i(rlast), .m_axi_rid_i(1'b1),
    .m_axi_rresp_i(2'b00), .m_rdma_req_valid_o(req_valid),
    .m_rdma_req_ready_i(req_ready), .m_rdma_req_o(req)
  );

  tb_wqe_mem tb_wqe_mem_inst (
    .clk_i(clk), .rstn_i(rstn), .arvalid_i(arvalid), .arready_o(arready),
    .araddr_i(araddr), .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata),
    .rlast_o(rlast)
  );

  ////////////////////////////////////////
  // WQE contents, same rules as memory
  ////////////////////////////////////////
  function automatic logic [7:0] wqe_opcode(int sq, int idx);
    if ((idx + sq) % 5 == 3) return 8'h04;
    if ((idx + sq) % 7 == 5) return 8'h02;
    return 8'h00;
  endfunction

  function automatic len_t wqe_length(int sq, int idx);
    if (idx % 4 == 0) return len_t'(1 + (idx * 53 + sq * 17) % 256);
    return len_t'(1 + (sq * 131 + idx * 977) % 9000);
  endfunction

  function automatic addr_t wqe_remote(int sq, int idx);
    return 64'h0000_A000_0000_0000 + (addr_t'(sq) << 24) + (addr_t'(idx) << 12);
  endfunction

  // SQ5 disabled, SQ6 has an illegal MTU code
  function automatic mtu_code_t sq_mtu_code(int sq);
    if (sq < 5) return mtu_code_t'(sq);
    if (sq == 6) return 3'd5;
    return 3'd2;
  endfunction

  function automatic logic sq_serviceable(sq_cfg_t c);
    return c.enable && (c.mtu_code <= 3'd4);
  endfunction

  function automatic int segment_count(int sq, int idx);
    len_t mtu;
    mtu = len_t'(256) << sq_mtu_code(sq);
    if (wqe_opcode(sq, idx) == 8'h04) return 1;
    if (wqe_opcode(sq, idx) == 8'h00) return int'((wqe_length(sq, idx) + mtu - 1) / mtu);
    return 0;
  endfunction

  function automatic rdma_req_t make_req(rdma_opc_t opc, int sq, logic last, len_t len,
                                         addr_t lva, addr_t rva);
    rdma_req_t r;
    r.opcode       = opc;
    r.qpn          = qpn_t'(sq);
    r.last         = last;
    r.len          = len;
    r.local_vaddr  = lva;
    r.remote_vaddr = rva;
    return r;
  endfunction

  function automatic int serviceable_total();
    int n;
    n = 0;
    for (int i = 0; i < NUM_SQ; i++) begin
      if (sq_serviceable(cfg_model[i])) n += int'(pi_model[i]);
    end
    return n;
  endfunction

  task automatic push_segments(int sq, int idx);
    len_t  mtu;
    len_t  len;
    len_t  rem;
    addr_t lva;
    addr_t rva;
    mtu = len_t'(256) << cfg_model[sq].mtu_code;
    len = wqe_length(sq, idx);
    lva = cfg_model[sq].local_vaddr;
    rva = wqe_remote(sq, idx);
    if (wqe_opcode(sq, idx) == 8'h04) begin
      exp_q.push_back(make_req(5'h0c, sq, 1'b1, len, lva, rva));
    end else if (wqe_opcode(sq, idx) == 8'h00) begin
      if (len <= mtu) begin
        exp_q.push_back(make_req(5'h0a, sq, 1'b1, len, lva, rva));
      end else begin
        exp_q.push_back(make_req(5'h06, sq, 1'b0, mtu, lva, rva));
        rem = len - mtu;
        while (rem > mtu) begin
          lva += addr_t'(mtu);
          rva += addr_t'(mtu);
          exp_q.push_back(make_req(5'h07, sq, 1'b0, mtu, lva, rva));
          rem -= mtu;
        end
        exp_q.push_back(make_req(5'h08, sq, 1'b1, rem, lva + addr_t'(mtu),
                                 rva + addr_t'(mtu)));
      end
    end
  endtask

  task automatic report_mismatch(string name, logic [255:0] exp_v, logic [255:0] act_v);
    $display("[FAIL] t=%0t %s expected=%0h actual=%0h", $time, name, exp_v, act_v);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic report_error(string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic write_config(int sq);
    sq_cfg_t c;
    c.enable      = (sq != 5);
    c.mtu_code    = sq_mtu_code(sq);
    c.ring_base   = RING_ORIGIN + (addr_t'(sq) << 16);
    c.local_vaddr = LOCAL_ORIGIN + (addr_t'(sq) << 32);
    @(posedge clk);
    #1;
    cfg_wr       = 1'b1;
    cfg_idx      = sq_idx_t'(sq);
    cfg          = c;
    cfg_model[sq] = c;
    @(posedge clk);
    #1;
    cfg_wr = 1'b0;
  endtask

  task automatic ring_doorbell(int sq, int pi);
    @(posedge clk);
    #1;
    db     = 1'b1;
    db_idx = sq_idx_t'(sq);
    db_pi  = ring_idx_t'(pi);
    if (ring_idx_t'(pi) > pi_model[sq]) pi_model[sq] = ring_idx_t'(pi);
    @(posedge clk);
    #1;
    db = 1'b0;
  endtask

  task automatic wait_drained();
    while (!(served == serviceable_total() && exp_q.size() == 0 && !req_valid)) begin
      @(posedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Random back-pressure on the request port
  always @(posedge clk) begin
    #1;
    req_ready = ($urandom % 4) != 0;
  end

  ////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////
  always_comb begin
    ar_sq      = araddr[18:16];
    exp_araddr = cfg_model[ar_sq].ring_base + (addr_t'(ci_model[ar_sq]) << 6);
    ar_allowed = sq_serviceable(cfg_model[ar_sq]) && (ci_model[ar_sq] < pi_model[ar_sq]);
  end

  always @(posedge clk) begin
    if (rstn) begin
      if (arvalid && arready) begin
        push_segments(int'(ar_sq), int'(ci_model[ar_sq]));
        ci_model[ar_sq] = ci_model[ar_sq] + 1;
        served++;
      end
      if (req_valid && req_ready && exp_q.size() > 0) void'(exp_q.pop_front());
    end
    exp_avail = exp_q.size() > 0;
    exp_head  = exp_avail ? exp_q[0] : '0;
  end

  a_ar_legal: assert property (@(posedge clk) disable iff (!rstn)
    arvalid && arready |-> ar_allowed)
    else report_error("AR issued for a disabled, misconfigured or empty SQ");

  a_ar_addr: assert property (@(posedge clk) disable iff (!rstn)
    arvalid && arready |-> araddr == exp_araddr)
    else report_mismatch("m_axi_araddr_o", exp_araddr, araddr);

  a_ar_attr: assert property (@(posedge clk) disable iff (!rstn)
    arvalid |-> {arlen, arsize, arburst, arcache, arprot, arid, arlock} ==
                {8'd0, 3'd6, AR_BURST_INCR, AR_CACHE, AR_PROT, 1'b1, 1'b0})
    else report_mismatch("m_axi_ar attributes",
                         {8'd0, 3'd6, AR_BURST_INCR, AR_CACHE, AR_PROT, 1'b1, 1'b0},
                         {arlen, arsize, arburst, arcache, arprot, arid, arlock});

  // Data phase opens in the cycle after the address handshake
  a_rready: assert property (@(posedge clk) disable iff (!rstn)
    arvalid && arready |=> rready)
    else report_error("m_axi_rready_o not raised in the cycle after the AR handshake");

  a_req_expected: assert property (@(posedge clk) disable iff (!rstn)
    req_valid |-> exp_avail)
    else report_error("RDMA request issued with no outstanding expected segment");

  a_req_value: assert property (@(posedge clk) disable iff (!rstn)
    req_valid && exp_avail |-> req == exp_head)
    else report_mismatch("m_rdma_req_o", exp_head, req);

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, queues were not drained", cycles);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  initial begin
    int segs;
    int wqes;
    void'($urandom(91200));
    rstn = 1'b0;
    cfg_wr = 1'b0;
    cfg_idx = '0;
    cfg = '0;
    db = 1'b0;
    db_idx = '0;
    db_pi = '0;
    req_ready = 1'b0;
    served = 0;
    cycles = 0;
    cycle_limit = 0;
    for (int i = 0; i < NUM_SQ; i++) begin
      cfg_model[i] = '0;
      pi_model[i]  = '0;
      ci_model[i]  = '0;
    end
    // Final producer indices: 9,12,6,6,6 on SQ0..4 and 10 on SQ7
    segs = 0;
    wqes = 0;
    for (int sq = 0; sq < NUM_SQ; sq++) begin
      int last;
      last = (sq == 0) ? 9 : (sq == 1) ? 12 : (sq == 7) ? 10 : (sq < 5) ? 6 : 0;
      for (int idx = 0; idx < last; idx++) segs += segment_count(sq, idx);
      wqes += last;
    end
    cycle_limit = 20 * segs + 20 * wqes + 1000;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn = 1'b1;

    for (int sq = 0; sq < NUM_SQ; sq++) write_config(sq);
    for (int sq = 0; sq < NUM_SQ; sq++) ring_doorbell(sq, (sq == 5 || sq == 6) ? 4 : 6);
    wait_drained();

    // More work on a few SQs, stale index on SQ1 while its WQEs are still pending
    ring_doorbell(1, 12);
    ring_doorbell(1, 8);
    ring_doorbell(7, 10);
    ring_doorbell(0, 9);
    wait_drained();
    repeat (20) @(posedge clk);

    if (exp_q.size() != 0 || served != wqes) begin
      $display("Run ended with %0d of %0d WQEs served", served, wqes);
      $display("=== FAIL ===");
      $fatal(1);
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_wqe_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_wqe_mem (
  input  wire logic          clk_i,
  input  wire logic          rstn_i,
  input  wire logic          arvalid_i,
  output logic               arready_o,
  input  wq_pkg::addr_t      araddr_i,
  output logic               rvalid_o,
  input  wire logic          rready_i,
  output wq_pkg::wqe_t       rdata_o,
  output logic               rlast_o
);
  import wq_pkg::*;

  addr_t addr_q;
  int    wait_q;
  logic  busy;
  logic  ar_hs;
  logic  r_hs;

  // Address encodes the SQ in bits 18:16 and the ring index in bits 15:6
  function automatic logic [7:0] wqe_opcode(int sq, int idx);
    if ((idx + sq) % 5 == 3) return 8'h04;
    if ((idx + sq) % 7 == 5) return 8'h02;
    return 8'h00;
  endfunction

  function automatic len_t wqe_length(int sq, int idx);
    if (idx % 4 == 0) return len_t'(1 + (idx * 53 + sq * 17) % 256);
    return len_t'(1 + (sq * 131 + idx * 977) % 9000);
  endfunction

  function automatic addr_t wqe_remote(int sq, int idx);
    return 64'h0000_A000_0000_0000 + (addr_t'(sq) << 24) + (addr_t'(idx) << 12);
  endfunction

  function automatic wqe_t build_wqe(addr_t addr);
    wqe_t w;
    int   sq;
    int   idx;
    sq  = int'(addr[18:16]);
    idx = int'(addr[15:6]);
    // Background words carry the full address
    w = {8{addr}};
    w[WQE_LEN_LSB +: 32]   = wqe_length(sq, idx);
    w[WQE_OPC_LSB +: 8]    = wqe_opcode(sq, idx);
    w[WQE_RADDR_LSB +: 64] = wqe_remote(sq, idx);
    return w;
  endfunction

  initial begin
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rlast_o   = 1'b0;
    rdata_o   = '0;
    busy      = 1'b0;
    wait_q    = 0;
    addr_q    = '0;
  end

  always @(posedge clk_i) begin
    ar_hs = arvalid_i && arready_o;
    r_hs  = rvalid_o && rready_i;
    if (ar_hs) begin
      addr_q = araddr_i;
      wait_q = int'($urandom % 6);
      busy   = 1'b1;
    end
    #1;
    if (!rstn_i) begin
      arready_o = 1'b0;
      rvalid_o  = 1'b0;
      rlast_o   = 1'b0;
      busy      = 1'b0;
    end else begin
      if (r_hs) begin
        rvalid_o = 1'b0;
        rlast_o  = 1'b0;
        busy     = 1'b0;
      end
      // Random response latency after the address phase
      if (busy && !rvalid_o) begin
        if (wait_q == 0) begin
          rvalid_o = 1'b1;
          rlast_o  = 1'b1;
          rdata_o  = build_wqe(addr_q);
        end else begin
          wait_q = wait_q - 1;
        end
      end
      arready_o = !busy && ($urandom % 3 != 0);
    end
  end

endmodule

`default_nettype wire
